// ==== dsp_top.f ====
verilog/dsp_arith_pkg.sv
verilog/dsp_bus_pkg.sv
verilog/dsp_mul_if.sv
verilog/booth_lane_mult.sv
verilog/dsp_simd_mult.sv
verilog/dsp_regs.sv
verilog/dsp_top.sv
tb/tb_dsp_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_dsp_top \
		-f dsp_top.f --Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim > sim.log 2>&1; cat sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tb_dsp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_top;
   import dsp_arith_pkg::*;
   import dsp_bus_pkg::*;

   typedef struct packed {
      wb_data_t a;
      wb_data_t b;
      logic     sgn;
      logic     dot;
      wb_data_t exp_hi;
      wb_data_t exp_lo;
   } row_t;

   localparam int N_ROWS = 9;
   localparam row_t ROWS [N_ROWS] = '{
      '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 1'b0, 32'hFFFE_0001, 32'hFFFE_0001},
      '{32'h0000_1234, 32'h5678_0000, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000},
      '{32'h0003_0007, 32'h0005_000B, 1'b0, 1'b0, 32'h0000_000F, 32'h0000_004D},
      '{32'h8000_8000, 32'h8000_8000, 1'b1, 1'b0, 32'h4000_0000, 32'h4000_0000},
      '{32'hFFFF_0003, 32'h0002_FFFB, 1'b1, 1'b0, 32'hFFFF_FFFE, 32'hFFFF_FFF1},
      '{32'h7FFF_8000, 32'h8000_7FFF, 1'b1, 1'b0, 32'hC000_8000, 32'hC000_8000},
      '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 1'b1, 32'h0000_0001, 32'hFFFC_0002},
      '{32'h0002_0003, 32'hFFFC_FFFB, 1'b1, 1'b1, 32'hFFFF_FFFF, 32'hFFFF_FFE9},
      '{32'h8000_8000, 32'h8000_8000, 1'b1, 1'b1, 32'h0000_0000, 32'h8000_0000}
   };

   logic     clk;
   logic     arst_n;
   logic     wb_cyc;
   logic     wb_stb;
   logic     wb_we;
   wb_adr_t  wb_adr;
   wb_data_t wb_dat_w;
   wb_data_t wb_dat_r;
   logic     wb_ack;
   int       errors = 0;
   int       tests = 0;
   int       fails = 0;
   logic [31:0] rng = 32'h5377_533f;

   dsp_top #(.LANE_W(16)) UUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic longint lane_val(input logic [15:0] v, input logic sgn);
      if (sgn) return {{48{v[15]}}, v};
      else return {48'h0, v};
   endfunction

   // reference result straight from the lane rules.
   function automatic wide_t model(input wb_data_t a, input wb_data_t b,
                                   input logic sgn, input logic dot);
      longint pl;
      longint ph;
      pl = lane_val(a[15:0], sgn) * lane_val(b[15:0], sgn);
      ph = lane_val(a[31:16], sgn) * lane_val(b[31:16], sgn);
      if (dot) return wide_t'(pl + ph);
      else return {ph[31:0], pl[31:0]};
   endfunction

   function automatic wb_data_t ctrl_word(input logic sgn, input logic dot);
      wb_data_t w;
      w = '0;
      w[CTRL_GO]     = 1'b1;
      w[CTRL_SIGNED] = sgn;
      w[CTRL_DOT]    = dot;
      return w;
   endfunction

   task automatic bus_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
      int n;
      n = 1;
      rdata = '0;
      @(posedge clk);
      #2;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      @(posedge clk);
      #2;
      while (!wb_ack && n < 20) begin
         @(posedge clk);
         #2;
         n++;
      end
      if (wb_ack) rdata = wb_dat_r;   // read data valid with ack.
      else begin
         $display("bus timeout: no ack within 20 cycles at address %h", adr);
         errors++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
      wb_data_t unused;
      bus_access(1'b1, adr, data, unused);
   endtask

   task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
      bus_access(1'b0, adr, '0, data);
   endtask

   task automatic wait_idle(output wb_data_t st);
      int n;
      n = 0;
      st = '0;
      st[STAT_BUSY] = 1'b1;
      while (st[STAT_BUSY] && n < 50) begin
         wb_read(REG_STATUS, st);
         n++;
      end
      if (st[STAT_BUSY]) begin
         $display("busy still set after 50 status reads");
         errors++;
      end
   endtask

   task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic run_op(input wb_data_t a, input wb_data_t b, input logic sgn,
                         input logic dot, input wide_t exp);
      wb_data_t st;
      wb_data_t lo;
      wb_data_t hi;
      wb_write(REG_A, a);
      wb_write(REG_B, b);
      wb_write(REG_CTRL, ctrl_word(sgn, dot));
      wait_idle(st);
      wb_read(REG_RES_LO, lo);
      wb_read(REG_RES_HI, hi);
      check_word("RES_LO", lo, exp[31:0]);
      check_word("RES_HI", hi, exp[63:32]);
   endtask

   task automatic report_test(input string name, input int e0);
      tests++;
      if (errors == e0) $display("test %0d %s: passed", tests, name);
      else begin
         fails++;
         $display("test %0d %s: failed", tests, name);
      end
   endtask

   initial begin
      int       e0;
      wb_data_t d;
      wb_data_t a;
      wb_data_t b;
      wide_t    exp_first;
      arst_n   = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      repeat (4) @(posedge clk);
      #2;
      arst_n = 1'b1;

      e0 = errors;
      wb_read(REG_STATUS, d);
      check_word("STATUS", d, '0);
      wb_read(REG_RES_LO, d);
      check_word("RES_LO", d, '0);
      wb_read(REG_RES_HI, d);
      check_word("RES_HI", d, '0);
      wb_read(5'h18, d);   // unmapped.
      check_word("UNMAPPED", d, '0);
      report_test("reset values", e0);

      for (int i = 0; i < N_ROWS; i++) begin
         e0 = errors;
         run_op(ROWS[i].a, ROWS[i].b, ROWS[i].sgn, ROWS[i].dot,
                {ROWS[i].exp_hi, ROWS[i].exp_lo});
         report_test($sformatf("table row %0d", i), e0);
      end

      // second go lands while the first is still busy.
      e0 = errors;
      a = 32'h8003_FFFE;
      b = 32'h7001_0005;
      exp_first = model(a, b, 1'b0, 1'b0);
      wb_write(REG_A, a);
      wb_write(REG_B, b);
      wb_write(REG_CTRL, ctrl_word(1'b0, 1'b0));
      wb_write(REG_CTRL, ctrl_word(1'b1, 1'b1));
      wait_idle(d);
      check_flag("OVERRUN", d[STAT_OVERRUN], 1'b1);
      wb_read(REG_RES_LO, d);
      check_word("RES_LO", d, exp_first[31:0]);
      wb_read(REG_RES_HI, d);
      check_word("RES_HI", d, exp_first[63:32]);
      wb_write(REG_CTRL, ctrl_word(1'b0, 1'b1));
      wait_idle(d);
      check_flag("OVERRUN", d[STAT_OVERRUN], 1'b0);
      report_test("overrun", e0);

      for (int i = 0; i < 40; i++) begin
         e0 = errors;
         rng = xorshift32(rng);
         a = rng;
         rng = xorshift32(rng);
         b = rng;
         run_op(a, b, i[0], i[1], model(a, b, i[0], i[1]));   // all four modes.
         report_test($sformatf("random %0d", i), e0);
      end

      $display("%0d tests, %0d failed, %0d errors", tests, fails, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/dsp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_top #(
   parameter int LANE_W = 16
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  dsp_bus_pkg::wb_adr_t  wb_adr,
   input  dsp_bus_pkg::wb_data_t wb_dat_w,
   output dsp_bus_pkg::wb_data_t wb_dat_r,
   output logic                  wb_ack
);

   dsp_mul_if mul ();

   dsp_regs u_regs (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .mul      (mul.regs)
   );

   // two lanes and the combine stage.
   dsp_simd_mult #(.LANE_W(LANE_W)) u_mult (
      .clk    (clk),
      .arst_n (arst_n),
      .mul    (mul.dp)
   );

endmodule

`default_nettype wire

// ==== verilog/dsp_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_regs (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  dsp_bus_pkg::wb_adr_t  wb_adr,
   input  dsp_bus_pkg::wb_data_t wb_dat_w,
   output dsp_bus_pkg::wb_data_t wb_dat_r,
   output logic                  wb_ack,
   dsp_mul_if.regs               mul
);
   import dsp_arith_pkg::*;
   import dsp_bus_pkg::*;

   logic     req;
   logic     wr;
   logic     rd;
   logic     go_wr;
   wb_data_t reg_a;
   wb_data_t reg_b;
   wb_data_t res_lo;
   wb_data_t res_hi;
   wb_data_t rd_mux;
   logic     ctrl_signed;
   logic     ctrl_dot;
   logic     busy;
   logic     overrun;
   logic     start_q;

   assign req   = wb_cyc & wb_stb & ~wb_ack;   // no new request during ack.
   assign wr    = req & wb_we;
   assign rd    = req & ~wb_we;
   assign go_wr = wr && (wb_adr == REG_CTRL) && wb_dat_w[CTRL_GO];

   always_comb begin
      rd_mux = '0;
      case (wb_adr)
         REG_A:      rd_mux = reg_a;
         REG_B:      rd_mux = reg_b;
         REG_CTRL: begin
            rd_mux[CTRL_SIGNED] = ctrl_signed;
            rd_mux[CTRL_DOT]    = ctrl_dot;
         end
         REG_STATUS: begin
            rd_mux[STAT_BUSY]    = busy;
            rd_mux[STAT_OVERRUN] = overrun;
         end
         REG_RES_LO: rd_mux = res_lo;
         REG_RES_HI: rd_mux = res_hi;
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack   <= 1'b0;
         wb_dat_r <= '0;
      end else begin
         wb_ack   <= req;
         wb_dat_r <= rd ? rd_mux : '0;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_a       <= '0;
         reg_b       <= '0;
         ctrl_signed <= 1'b0;
         ctrl_dot    <= 1'b0;
      end else if (wr) begin
         case (wb_adr)
            REG_A: reg_a <= wb_dat_w;
            REG_B: reg_b <= wb_dat_w;
            REG_CTRL: begin
               ctrl_signed <= wb_dat_w[CTRL_SIGNED];
               ctrl_dot    <= wb_dat_w[CTRL_DOT];
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         start_q <= 1'b0;
         busy    <= 1'b0;
         overrun <= 1'b0;
         res_lo  <= '0;
         res_hi  <= '0;
      end else begin
         start_q <= go_wr & ~busy;
         if (go_wr && !busy) begin
            busy <= 1'b1;
         end else if (mul.done) begin
            busy <= 1'b0;
         end
         if (go_wr) overrun <= busy;   // cleared by an accepted go.
         if (mul.done) begin
            res_lo <= mul.result[31:0];
            res_hi <= mul.result[63:32];
         end
      end
   end

   assign mul.start     = start_q;
   assign mul.a_word    = reg_a;
   assign mul.b_word    = reg_b;
   assign mul.is_signed = ctrl_signed;
   assign mul.mode      = ctrl_dot ? OP_DOT : OP_PAIR;

   a_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
      wb_ack |=> !wb_ack);

   a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(mul.start) |-> !$past(busy));

endmodule

`default_nettype wire

// ==== verilog/dsp_simd_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_simd_mult #(
   parameter int LANE_W = 16
) (
   input  logic  clk,
   input  logic  arst_n,
   dsp_mul_if.dp mul
);
   import dsp_arith_pkg::*;

   localparam int PW = $bits(prod_t);
   localparam int WW = $bits(wide_t);

   lane_t    a_lo;
   lane_t    a_hi;
   lane_t    b_lo;
   lane_t    b_hi;
   prod_t    p_lo;
   prod_t    p_hi;
   logic     v1;
   logic     sgn1;
   op_mode_t mode1;
   wide_t    ext_lo;
   wide_t    ext_hi;
   wide_t    combined;

   assign a_lo = lane_t'(mul.a_word[LANE_W-1:0]);
   assign a_hi = lane_t'(mul.a_word[2*LANE_W-1:LANE_W]);
   assign b_lo = lane_t'(mul.b_word[LANE_W-1:0]);
   assign b_hi = lane_t'(mul.b_word[2*LANE_W-1:LANE_W]);

   booth_lane_mult #(.LANE_W(LANE_W)) u_lo (
      .clk       (clk),
      .arst_n    (arst_n),
      .x         (a_lo),
      .y         (b_lo),
      .is_signed (mul.is_signed),
      .product   (p_lo)
   );

   booth_lane_mult #(.LANE_W(LANE_W)) u_hi (
      .clk       (clk),
      .arst_n    (arst_n),
      .x         (a_hi),
      .y         (b_hi),
      .is_signed (mul.is_signed),
      .product   (p_hi)
   );

   // stage 1 side band.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         v1    <= 1'b0;
         sgn1  <= 1'b0;
         mode1 <= OP_PAIR;
      end else begin
         v1    <= mul.start;
         sgn1  <= mul.is_signed;
         mode1 <= mul.mode;
      end
   end

   assign ext_lo = {{(WW-PW){sgn1 & p_lo[PW-1]}}, p_lo};
   assign ext_hi = {{(WW-PW){sgn1 & p_hi[PW-1]}}, p_hi};

   assign combined = (mode1 == OP_DOT) ? ext_lo + ext_hi : {p_hi, p_lo};

   // stage 2.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mul.done   <= 1'b0;
         mul.result <= '0;
      end else begin
         mul.done   <= v1;
         mul.result <= combined;
      end
   end

   a_done_latency: assert property (@(posedge clk) disable iff (!arst_n)
      mul.start |-> ##2 mul.done);

endmodule

`default_nettype wire

// ==== verilog/booth_lane_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module booth_lane_mult #(
   parameter int LANE_W = 16
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  dsp_arith_pkg::lane_t x,
   input  dsp_arith_pkg::lane_t y,
   input  logic                 is_signed,
   output dsp_arith_pkg::prod_t product
);
   import dsp_arith_pkg::*;

   localparam int NW = LANE_W/2 + 1;   // windows.
   localparam int RW = LANE_W + 2;     // partial product row.

   // leading constant standing in for the sign extension of every row.
   function automatic prod_t sign_const();
      prod_t k;
      k = '0;
      for (int i = 0; i < NW; i++) begin
         k = k - (prod_t'(1) << (LANE_W + 1 + 2*i));
      end
      return k;
   endfunction

   localparam prod_t SIGN_K = sign_const();

   logic              x_ext;
   logic              y_ext;
   logic [LANE_W+2:0] xw;
   logic [LANE_W:0]   ye;
   booth_digit_t      dig [NW];
   logic [RW-1:0]     row [NW];
   prod_t             pp_sum;
   prod_t             x_full;
   prod_t             y_full;
   prod_t             ref_prod;   // plain multiply.

   assign x_ext = is_signed & x[LANE_W-1];
   assign y_ext = is_signed & y[LANE_W-1];

   // top window is all sign bits in signed mode and so decodes to zero.
   assign xw = {x_ext, x_ext, x[LANE_W-1:0], 1'b0};
   assign ye = {y_ext, y[LANE_W-1:0]};

   for (genvar i = 0; i < NW; i++) begin : g_pp
      logic [RW-1:0] mag;
      logic [RW-1:0] word;

      assign dig[i] = booth_decode(xw[2*i+2 -: 3]);

      always_comb begin
         if (dig[i].zero) begin
            mag = '0;
         end else if (dig[i].double) begin
            mag = {ye, 1'b0};
         end else begin
            mag = {ye[LANE_W], ye};
         end
      end

      assign word   = dig[i].negate ? ~mag : mag;   // +1 added in the sum.
      assign row[i] = {~word[RW-1], word[RW-2:0]};
   end

   always_comb begin
      pp_sum = SIGN_K;
      for (int i = 0; i < NW; i++) begin
         pp_sum = pp_sum + (prod_t'(row[i]) << (2*i));
         pp_sum = pp_sum + (prod_t'(dig[i].negate) << (2*i));   // negate correction.
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         product <= '0;
      end else begin
         product <= pp_sum;
      end
   end

   assign x_full   = {{LANE_W{x_ext}}, x[LANE_W-1:0]};
   assign y_full   = {{LANE_W{y_ext}}, y[LANE_W-1:0]};
   assign ref_prod = x_full * y_full;

   // booth sum against the plain product.
   a_product_ok: assert property (@(posedge clk) disable iff (!arst_n)
      product == $past(ref_prod));

endmodule

`default_nettype wire

// ==== verilog/dsp_mul_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dsp_mul_if;
   import dsp_arith_pkg::*;
   import dsp_bus_pkg::*;

   logic     start;    // one cycle pulse.
   wb_data_t a_word;
   wb_data_t b_word;
   logic     is_signed;
   op_mode_t mode;

   logic     done;     // start plus two cycles.
   wide_t    result;

   modport regs (
      output start, a_word, b_word, is_signed, mode,
      input  done, result
   );

   modport dp (
      input  start, a_word, b_word, is_signed, mode,
      output done, result
   );

endinterface

`default_nettype wire

// ==== verilog/dsp_bus_pkg.sv ====
`default_nettype none

package dsp_bus_pkg;

   typedef logic [31:0] wb_data_t;
   typedef logic [4:0]  wb_adr_t;   // byte address.

   // register map.
   localparam wb_adr_t REG_A      = 5'h00;
   localparam wb_adr_t REG_B      = 5'h04;
   localparam wb_adr_t REG_CTRL   = 5'h08;
   localparam wb_adr_t REG_STATUS = 5'h0C;
   localparam wb_adr_t REG_RES_LO = 5'h10;
   localparam wb_adr_t REG_RES_HI = 5'h14;

   // control bits.
   localparam int CTRL_GO     = 0;   // self clearing.
   localparam int CTRL_SIGNED = 1;
   localparam int CTRL_DOT    = 2;

   // status bits.
   localparam int STAT_BUSY    = 0;
   localparam int STAT_OVERRUN = 1;

endpackage

`default_nettype wire

// ==== verilog/dsp_arith_pkg.sv ====
`default_nettype none

package dsp_arith_pkg;

   localparam int LANE_W_DEF = 16;

   typedef logic [LANE_W_DEF-1:0]   lane_t;
   typedef logic [2*LANE_W_DEF-1:0] prod_t;
   typedef logic [4*LANE_W_DEF-1:0] wide_t;

   typedef enum logic {
      OP_PAIR = 1'b0,   // two independent lane products.
      OP_DOT  = 1'b1    // lane products summed.
   } op_mode_t;

   // one radix-4 digit out of a 3-bit multiplier window.
   typedef struct packed {
      logic negate;
      logic double;
      logic zero;
   } booth_digit_t;

   function automatic booth_digit_t booth_decode(input logic [2:0] win);
      booth_digit_t d;
      d.zero   = (win == 3'b000) || (win == 3'b111);
      d.double = (win == 3'b011) || (win == 3'b100);
      d.negate = win[2] & ~d.zero;   // 111 is plain zero.
      return d;
   endfunction

endpackage

`default_nettype wire
